// File: all.f
logic/board_pkg.sv
logic/baud_timer.sv
logic/uart_tx_fsm.sv
logic/tx_shift_reg.sv
logic/dip_reporter.sv
logic/board_top.sv
verification/uart_rx_model.sv
verification/board_top_tb.sv

// File: Makefile
# Verilator simulation of the DIP/LED/UART status console

VERILATOR = verilator
VFLAGS    = --binary --assert --timing
TOP       = board_top_tb
FILELIST  = all.f

.PHONY: sim clean

# build, run, and pass only if the run prints the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

// File: verification/board_top_tb.sv
// board_top testbench; bit period 64 >> 3 = 8 clocks, LCG seed 18, stops at the first failed check
`timescale 1ns/1ps

module board_top_tb;

  localparam int CLKS_PER_BIT = 64;
  localparam int SIM_SPEEDUP  = 3;
  localparam int CLK_PERIOD   = 40;
  localparam int DRIVE_DLY    = 1;
  localparam int RESET_CYCLES = 16;
  // bit length straight from the speed-up rule
  localparam int BIT_CLKS     = CLKS_PER_BIT / (2 ** SIM_SPEEDUP);
  localparam int FRAME_CLKS   = board_pkg::FRAME_BITS * BIT_CLKS;
  // two frames plus sync and load latency
  localparam int SETTLE_LONG  = 2 * FRAME_CLKS + 16;
  localparam int NUM_STEPS    = 40;
  localparam int DIRECTED_STEPS = 6;
  localparam int CYCLE_LIMIT  =
    (NUM_STEPS + DIRECTED_STEPS) * (SETTLE_LONG + 2 * FRAME_CLKS) + RESET_CYCLES + 200;
  localparam logic [31:0] SEED = 32'd18;

  logic             clk;
  logic             i_rst_n;
  board_pkg::dip_t  i_dip;
  board_pkg::led_t  o_led;
  logic             o_uart_td;

  logic             rx_valid;
  board_pkg::byte_t rx_char;
  int               rx_count;
  int               rx_bit_time;
  logic             rx_frame_err;
  logic             rx_misaligned;

  int          cycle_cnt = 0;
  int          dip_changes = 0;
  logic        first_seen = 1'b0;
  logic [31:0] lcg_state;

  board_top #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .SIM_SPEEDUP  (SIM_SPEEDUP)
  ) dut_i (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_dip     (i_dip),
    .o_led     (o_led),
    .o_uart_td (o_uart_td)
  );

  // terminal side of the serial line
  uart_rx_model #(
    .BIT_CLKS (BIT_CLKS)
  ) rx_i (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_rxd        (o_uart_td),
    .o_valid      (rx_valid),
    .o_char       (rx_char),
    .o_count      (rx_count),
    .o_bit_time   (rx_bit_time),
    .o_frame_err  (rx_frame_err),
    .o_misaligned (rx_misaligned)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic report_mismatch(input string sig, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    $display("** Error at %0d ns: %s expected 0x%0h, got 0x%0h", $time, sig, exp_val, act_val);
    abort_run();
  endtask

  task automatic report_problem(input string msg);
    $display("** Error at %0d ns: %s", $time, msg);
    abort_run();
  endtask

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // '0'..'9' then 'A'..'F'
  function automatic board_pkg::byte_t hex_ascii(input board_pkg::dip_t v);
    if (v <= 4'd9) begin
      return 8'h30 + {4'd0, v};
    end
    return 8'h41 + {4'd0, v - 4'd10};
  endfunction

  function automatic board_pkg::dip_t ascii_nibble(input board_pkg::byte_t c);
    board_pkg::byte_t d;
    if (c >= 8'h41) begin
      d = c - 8'h41 + 8'd10;
    end else begin
      d = c - 8'h30;
    end
    return d[3:0];
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  // new switch value a little after the edge
  task automatic drive_dip(input board_pkg::dip_t v);
    @(posedge clk);
    #DRIVE_DLY;
    if (v != i_dip) begin
      dip_changes = dip_changes + 1;
    end
    i_dip = v;
  endtask

  task automatic wait_rx_count(input int target);
    while (rx_count < target) @(posedge clk);
  endtask

  task automatic wait_frame_start();
    do @(posedge clk); while (o_uart_td);
  endtask

  // run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      report_problem($sformatf("timeout, run still going after %0d cycles", CYCLE_LIMIT));
    end
  end

  // idle line in reset, dark LEDs until the first start bit
  always @(posedge clk) begin
    if (cycle_cnt >= 1) begin
      if (!i_rst_n) begin
        assert (o_uart_td) else report_mismatch("o_uart_td", 32'd1, 32'(o_uart_td));
      end
      if (!first_seen && o_uart_td) begin
        assert (o_led == '0) else report_mismatch("o_led", 32'd0, 32'(o_led));
      end
    end
    if (i_rst_n && !o_uart_td) begin
      first_seen <= 1'b1;
    end
  end

  // framing, bit time, LEDs and count bound for each character
  always @(posedge clk) begin
    if (rx_valid) begin
      assert (!rx_frame_err)
        else report_problem("framing error, start bit high or line low at stop or frame end");
      assert (!rx_misaligned) else report_problem("a line edge fell inside a bit period");
      assert (rx_bit_time == BIT_CLKS)
        else report_mismatch("bit time", 32'(BIT_CLKS), 32'(rx_bit_time));
      assert (o_led[3:0] == ascii_nibble(rx_char))
        else report_mismatch("o_led[3:0]", 32'(ascii_nibble(rx_char)), 32'(o_led[3:0]));
      assert (32'(o_led[7:4]) == 32'(rx_count % 16))
        else report_mismatch("o_led[7:4]", 32'(rx_count % 16), 32'(o_led[7:4]));
      assert (rx_count <= dip_changes + 1)
        else report_problem($sformatf("%0d characters after only %0d switch changes",
                                      rx_count, dip_changes));
    end
  end

  initial begin
    int              base;
    int              step;
    board_pkg::dip_t v;
    i_rst_n   = 1'b0;
    // nonzero through reset, differs from the reset value of zero
    i_dip     = 4'hA;
    lcg_state = SEED;
    wait_cycles(RESET_CYCLES);
    #DRIVE_DLY;
    i_rst_n = 1'b1;

    // first report of the value held through reset
    wait_rx_count(1);
    assert (rx_char == hex_ascii(4'hA))
      else report_mismatch("rx_char", 32'(hex_ascii(4'hA)), 32'(rx_char));
    wait_cycles(SETTLE_LONG);
    assert (rx_count == 1) else report_mismatch("rx_count", 32'd1, 32'(rx_count));

    // several changes inside one frame coalesce into one more character
    base = rx_count;
    drive_dip(4'h3);
    wait_frame_start();
    drive_dip(4'h7);
    wait_cycles(10);
    drive_dip(4'hC);
    wait_cycles(10);
    drive_dip(4'h5);
    wait_rx_count(base + 2);
    wait_cycles(SETTLE_LONG);
    assert (rx_count <= base + 2)
      else report_mismatch("rx_count", 32'(base + 2), 32'(rx_count));
    assert (rx_char == hex_ascii(4'h5))
      else report_mismatch("rx_char", 32'(hex_ascii(4'h5)), 32'(rx_char));

    // going back to the value in flight leaves nothing to send
    base = rx_count;
    drive_dip(4'h9);
    wait_frame_start();
    drive_dip(4'h2);
    wait_cycles(20);
    drive_dip(4'h9);
    wait_cycles(SETTLE_LONG);
    assert (rx_count == base + 1)
      else report_mismatch("rx_count", 32'(base + 1), 32'(rx_count));
    assert (rx_char == hex_ascii(4'h9))
      else report_mismatch("rx_char", 32'(hex_ascii(4'h9)), 32'(rx_char));

    // random values with long or short settle times
    for (step = 0; step < NUM_STEPS; step++) begin
      lcg_state = lcg_step(lcg_state);
      v = lcg_state[19:16];
      drive_dip(v);
      lcg_state = lcg_step(lcg_state);
      if (lcg_state[24]) begin
        wait_cycles(SETTLE_LONG);
        assert (rx_char == hex_ascii(v))
          else report_mismatch("rx_char", 32'(hex_ascii(v)), 32'(rx_char));
        assert (o_led[3:0] == v) else report_mismatch("o_led[3:0]", 32'(v), 32'(o_led[3:0]));
      end else begin
        // somewhere inside a frame
        wait_cycles(4 + int'(lcg_state[21:16]) % (FRAME_CLKS / 2));
      end
    end

    wait_cycles(SETTLE_LONG);
    assert (rx_char == hex_ascii(i_dip))
      else report_mismatch("rx_char", 32'(hex_ascii(i_dip)), 32'(rx_char));
    $display("TEST OK");
    $finish;
  end

endmodule

// File: verification/uart_rx_model.sv
// 8N1 receiver model; BIT_CLKS as in the sender and >= 2, bit time assumes data bit 7 low
`timescale 1ns/1ps

module uart_rx_model #(
  parameter int BIT_CLKS = 8
) (
  input  logic             clk,
  input  logic             i_rst_n,
  input  logic             i_rxd,
  output logic             o_valid,
  output board_pkg::byte_t o_char,
  output int               o_count,
  output int               o_bit_time,
  output logic             o_frame_err,
  output logic             o_misaligned
);

  localparam int FRAME_CLKS = board_pkg::FRAME_BITS * BIT_CLKS;

  // receiver state, updated in place sample by sample
  logic              busy;
  logic              prev_rxd;
  logic              off_grid;
  int                cyc;
  int                last_rise;
  board_pkg::frame_t samples;

  always @(posedge clk) begin
    o_valid <= 1'b0;
    if (!i_rst_n) begin
      busy      = 1'b0;
      off_grid  = 1'b0;
      cyc       = 0;
      last_rise = 0;
      samples   = '1;
      o_count      <= 0;
      o_char       <= '0;
      o_bit_time   <= 0;
      o_frame_err  <= 1'b0;
      o_misaligned <= 1'b0;
    end else if (!busy) begin
      // falling edge of the start bit opens a frame, cycle 0
      if (!i_rxd) begin
        busy      = 1'b1;
        cyc       = 0;
        last_rise = 0;
        off_grid  = 1'b0;
        samples   = '1;
      end
    end else begin
      cyc = cyc + 1;
      // every edge must land on a bit boundary
      if ((i_rxd != prev_rxd) && ((cyc % BIT_CLKS) != 0)) begin
        off_grid = 1'b1;
      end
      // last rise is the edge into the stop bit, since data bit 7 is low
      if (i_rxd && !prev_rxd) begin
        last_rise = cyc;
      end
      // mid-bit sample, shifted in LSB first
      if ((cyc < FRAME_CLKS) && ((cyc % BIT_CLKS) == (BIT_CLKS / 2))) begin
        samples = {i_rxd, samples[9:1]};
      end
      // one full frame later the line must be back at mark
      if (cyc == FRAME_CLKS) begin
        busy = 1'b0;
        o_valid      <= 1'b1;
        o_char       <= samples[8:1];
        o_count      <= o_count + 1;
        o_bit_time   <= last_rise / (board_pkg::FRAME_BITS - 1);
        o_frame_err  <= samples[0] | ~samples[9] | ~i_rxd;
        o_misaligned <= off_grid;
      end
    end
    prev_rxd = i_rxd;
  end

endmodule

// File: logic/board_top.sv
// status console top; SIM_SPEEDUP shortens the bit by 2**SIM_SPEEDUP and must leave at least 1 clock
`timescale 1ns/1ps

module board_top #(
  parameter int CLKS_PER_BIT = 64,
  parameter int SIM_SPEEDUP  = 3
) (
  input  logic            clk,
  input  logic            i_rst_n,
  input  board_pkg::dip_t i_dip,
  output board_pkg::led_t o_led,
  output logic            o_uart_td
);

  // scaled bit length, same effect as dividing the baud scaler
  localparam int BIT_CLKS_RAW = CLKS_PER_BIT >> SIM_SPEEDUP;
  localparam int BIT_CLKS     = (BIT_CLKS_RAW > 0) ? BIT_CLKS_RAW : 1;

  logic             pending;
  logic             load;
  logic             run;
  logic             shift;
  logic             bit_tick;
  board_pkg::byte_t tx_char;

  // switch sampling, change detection and LEDs
  dip_reporter dip_reporter_i (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_dip     (i_dip),
    .i_load    (load),
    .o_pending (pending),
    .o_char    (tx_char),
    .o_led     (o_led)
  );

  // frame sequencing
  uart_tx_fsm uart_tx_fsm_i (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_pending  (pending),
    .i_bit_tick (bit_tick),
    .o_load     (load),
    .o_run      (run),
    .o_shift    (shift)
  );

  // bit period
  baud_timer #(
    .BIT_CLKS (BIT_CLKS)
  ) baud_timer_i (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_run      (run),
    .o_bit_tick (bit_tick)
  );

  // serializer driving the transmit pin
  tx_shift_reg tx_shift_reg_i (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_load  (load),
    .i_shift (shift),
    .i_char  (tx_char),
    .o_txd   (o_uart_td)
  );

endmodule

// File: logic/dip_reporter.sv
// switch change reporter; two-flop sync only, no debounce, last reported value starts at zero
`timescale 1ns/1ps

module dip_reporter (
  input  logic             clk,
  input  logic             i_rst_n,
  input  board_pkg::dip_t  i_dip,
  input  logic             i_load,
  output logic             o_pending,
  output board_pkg::byte_t o_char,
  output board_pkg::led_t  o_led
);

  board_pkg::dip_t dip_meta_q;
  board_pkg::dip_t dip_sync_q;
  board_pkg::dip_t reported_q;
  logic [3:0]      rpt_cnt_q;
  logic            pending_q;

  // two-flop synchronizer for the asynchronous switch bank
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      dip_meta_q <= '0;
      dip_sync_q <= '0;
    end else begin
      dip_meta_q <= i_dip;
      dip_sync_q <= dip_meta_q;
    end
  end

  // last reported value and report count, both shown on the LEDs
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      reported_q <= '0;
      rpt_cnt_q  <= '0;
    end else if (i_load) begin
      // the value sent is whatever is synchronized at load time
      reported_q <= dip_sync_q;
      // wraps after 16 reports
      rpt_cnt_q  <= rpt_cnt_q + 1'b1;
    end
  end

  // pending is registered one cycle behind the synchronized value
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      pending_q <= 1'b0;
    end else if (i_load) begin
      // reported catches up on this same edge
      pending_q <= 1'b0;
    end else begin
      // a return to the reported value before sending clears the request
      pending_q <= (dip_sync_q != reported_q);
    end
  end

  assign o_pending = pending_q;

  // hex digit encoder
  always_comb begin
    if (dip_sync_q < 4'd10) begin
      // '0' to '9'
      o_char = board_pkg::ASCII_ZERO + {4'h0, dip_sync_q};
    end else begin
      // 'A' to 'F'
      o_char = board_pkg::ASCII_ALPHA_OFS + {4'h0, dip_sync_q};
    end
  end

  assign o_led = {rpt_cnt_q, reported_q};

endmodule

// File: logic/tx_shift_reg.sv
// 8N1 frame shifter; idle line is high after reset and after each frame, load wins over shift
`timescale 1ns/1ps

module tx_shift_reg (
  input  logic             clk,
  input  logic             i_rst_n,
  input  logic             i_load,
  input  logic             i_shift,
  input  board_pkg::byte_t i_char,
  output logic             o_txd
);

  board_pkg::frame_t frame_q;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      // all ones so the line idles at mark level
      frame_q <= '1;
    end else if (i_load) begin
      // stop bit, data LSB first, start bit
      frame_q <= {1'b1, i_char, 1'b0};
    end else if (i_shift) begin
      // fill with ones so the line returns to idle after the stop bit
      frame_q <= {1'b1, frame_q[9:1]};
    end
  end

  // serial line is always the lowest bit
  assign o_txd = frame_q[0];

endmodule

// File: logic/uart_tx_fsm.sv
// transmit sequencer; ignores i_pending for the whole frame, so reports arriving mid-frame coalesce
`timescale 1ns/1ps

module uart_tx_fsm (
  input  logic clk,
  input  logic i_rst_n,
  input  logic i_pending,
  input  logic i_bit_tick,
  output logic o_load,
  output logic o_run,
  output logic o_shift
);

  // enough bits to count FRAME_BITS ticks
  localparam int BCNT_W = $clog2(board_pkg::FRAME_BITS + 1);
  localparam logic [BCNT_W-1:0] BCNT_LAST = BCNT_W'(board_pkg::FRAME_BITS - 1);

  board_pkg::tx_state_t state_q;
  logic [BCNT_W-1:0]    bit_cnt_q;
  logic                 load_q;
  logic                 last_tick;

  // tick that ends the stop bit
  assign last_tick = i_bit_tick && (bit_cnt_q == BCNT_LAST);

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      state_q   <= board_pkg::IDLE;
      bit_cnt_q <= '0;
      load_q    <= 1'b0;
    end else begin
      // load is a single-cycle pulse
      load_q <= 1'b0;
      case (state_q)
        board_pkg::IDLE: begin
          bit_cnt_q <= '0;
          if (load_q) begin
            // shift register and reporter capture on this edge
            state_q <= board_pkg::SHIFT;
          end else if (i_pending) begin
            // pending is still high during the load cycle, guarded above
            load_q <= 1'b1;
          end
        end
        board_pkg::SHIFT: begin
          if (last_tick) begin
            state_q   <= board_pkg::IDLE;
            bit_cnt_q <= '0;
          end else if (i_bit_tick) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
          end
        end
        default: begin
          state_q   <= board_pkg::IDLE;
          bit_cnt_q <= '0;
        end
      endcase
    end
  end

  assign o_load = load_q;

  // baud timer runs only while a frame is on the line
  assign o_run = (state_q == board_pkg::SHIFT);

  // every tick in a frame moves one bit out, including the stop bit
  assign o_shift = o_run & i_bit_tick;

endmodule

// File: logic/baud_timer.sv
// bit period timer; BIT_CLKS must be at least 1, count restarts from zero whenever i_run drops
`timescale 1ns/1ps

module baud_timer #(
  parameter int BIT_CLKS = 8
) (
  input  logic clk,
  input  logic i_rst_n,
  input  logic i_run,
  output logic o_bit_tick
);

  // counter needs at least one bit even for a one-cycle bit period
  localparam int CNT_W = (BIT_CLKS > 1) ? $clog2(BIT_CLKS) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(BIT_CLKS - 1);

  logic [CNT_W-1:0] cnt_q;
  logic             wrap;

  // tick on the last cycle of each bit period
  assign wrap = (cnt_q == CNT_LAST);

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      cnt_q <= '0;
    end else if (!i_run) begin
      // held at zero so the first tick is a full bit after the frame starts
      cnt_q <= '0;
    end else if (wrap) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // qualified with i_run so a stale count never produces a tick while idle
  assign o_bit_tick = i_run & wrap;

endmodule

// File: logic/board_pkg.sv
// shared widths and encodings for the DIP/LED/UART status console; frame is 8N1 with no parity
package board_pkg;

  // one ASCII character as sent on the serial line
  typedef logic [7:0] byte_t;

  // raw or synchronized DIP switch bank
  typedef logic [3:0] dip_t;

  // LED bank
  // upper nibble is the report count mod 16, lower nibble is the last reported value
  typedef logic [7:0] led_t;

  // full UART frame as held in the shift register
  // bit 0 is the start bit, bits 8:1 the data LSB first, bit 9 the stop bit
  typedef logic [9:0] frame_t;

  // number of bit periods in one frame
  localparam int FRAME_BITS = 10;

  // transmit FSM states
  typedef enum logic {
    IDLE  = 1'b0,
    SHIFT = 1'b1
  } tx_state_t;

  // ASCII codes used by the hex encoder
  localparam byte_t ASCII_ZERO = 8'h30;
  // 'A' minus ten, so a nibble of 10 maps straight to 'A'
  localparam byte_t ASCII_ALPHA_OFS = 8'h37;

endpackage
